// File: common/cpuPkg.sv
package cpuPkg;

    // datapath and address widths
    localparam int dataWidth = 16;
    localparam int addrWidth = 8;

    // instruction field widths
    localparam int opcodeWidth = 4;
    localparam int fieldWidth  = dataWidth - opcodeWidth;
    localparam int aluOpWidth  = 4;
    localparam int aluImmWidth = dataWidth - opcodeWidth - aluOpWidth;

    // instruction buffer sizing
    localparam int bufferDepth      = 4;
    localparam int bufferPtrWidth   = $clog2(bufferDepth);
    localparam int bufferCountWidth = $clog2(bufferDepth + 1);

    // divide by zero saturates to all ones
    localparam logic [dataWidth-1:0] divZeroResult = 16'hFFFF;

    // opcode 0 and anything above opHalt behave as a no operation
    typedef enum logic [opcodeWidth-1:0] {
        opLdi      = 4'h1,
        opLoad     = 4'h2,
        opStore    = 4'h3,
        opAluImm   = 4'h4,
        opAluMem   = 4'h5,
        opJump     = 4'h6,
        opJumpZero = 4'h7,
        opOut      = 4'h8,
        opHalt     = 4'h9
    } opcodeT;

    // same order as the original sixteen operation ALU
    typedef enum logic [aluOpWidth-1:0] {
        aluAdd, aluSub, aluMul, aluDiv,
        aluShl, aluShr, aluRol, aluRor,
        aluAnd, aluOr, aluXor, aluNor,
        aluNand, aluXnor, aluGreater, aluEqual
    } aluOpT;

    // address form, low bits of field are the address, all of it the ldi immediate
    typedef struct packed {
        opcodeT                opcode;
        logic [fieldWidth-1:0] field;
    } addrFormT;

    // alu form, operand is an immediate or a data address
    typedef struct packed {
        opcodeT                 opcode;
        aluOpT                  aluOp;
        logic [aluImmWidth-1:0] operand;
    } aluFormT;

    // one instruction word, two decodes
    typedef union packed {
        addrFormT addrForm;
        aluFormT  aluForm;
    } instrU;

endpackage

// File: execute/aluUnit.sv
module aluUnit (
    input  cpuPkg::aluOpT                aluOp,
    input  logic [cpuPkg::dataWidth-1:0] operandA,
    input  logic [cpuPkg::dataWidth-1:0] operandB,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    // compare results as a full-width 0 or 1
    logic [dataWidth-1:0] greaterWord;
    logic [dataWidth-1:0] equalWord;

    assign greaterWord = {{(dataWidth - 1){1'b0}}, (operandA > operandB)};
    assign equalWord   = {{(dataWidth - 1){1'b0}}, (operandA == operandB)};

    always_comb begin
        case (aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            // low half of the product only
            aluMul: result = operandA * operandB;
            aluDiv: begin
                if (operandB == '0) begin
                    result = divZeroResult;
                end else begin
                    result = operandA / operandB;
                end
            end
            // shifts and rotates ignore operandB
            aluShl: result = operandA << 1;
            aluShr: result = operandA >> 1;
            aluRol: result = {operandA[dataWidth-2:0], operandA[dataWidth-1]};
            aluRor: result = {operandA[0], operandA[dataWidth-1:1]};
            // bitwise group
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluNor:  result = ~(operandA | operandB);
            aluNand: result = ~(operandA & operandB);
            aluXnor: result = ~(operandA ^ operandB);
            // unsigned compares
            aluGreater: result = greaterWord;
            aluEqual:   result = equalWord;
            default:    result = '0;
        endcase
    end

endmodule

// File: execute/executeUnit.sv
module executeUnit (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [cpuPkg::dataWidth-1:0] headWord,
    input  logic [cpuPkg::addrWidth-1:0] headAddr,
    input  logic                         empty,
    output logic                         pop,
    output logic                         redirect,
    output logic [cpuPkg::addrWidth-1:0] redirectAddr,
    output logic                         haltReq,
    output logic                         halted,
    output logic                         outValid,
    output logic [cpuPkg::dataWidth-1:0] outData
);
    import cpuPkg::*;

    instrU  instr;
    opcodeT opcode;

    logic [dataWidth-1:0] acc;
    // data memory with a combinational read
    logic [dataWidth-1:0] dataMem [0:(1 << addrWidth)-1];

    logic [addrWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWord;
    logic [dataWidth-1:0] aluOperandB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] ldiValue;
    logic [addrWidth-1:0] jumpTarget;
    logic [addrWidth-1:0] nextAddr;
    logic                 jumpTaken;
    logic                 isHalt;
    logic                 isOut;

    assign instr  = headWord;
    assign opcode = instr.addrForm.opcode;

    // never stall, but nothing after halt and nothing stale during a redirect
    assign pop = ~empty & ~halted & ~redirect;

    // both forms keep the data address in the low byte
    assign memAddr = instr.addrForm.field[addrWidth-1:0];
    assign memWord = dataMem[memAddr];

    // immediates are zero-extended
    assign aluOperandB = (opcode == opAluImm)
                       ? {{(dataWidth - aluImmWidth){1'b0}}, instr.aluForm.operand}
                       : memWord;
    assign ldiValue    = {{(dataWidth - fieldWidth){1'b0}}, instr.addrForm.field};

    aluUnit aluInst (
        .aluOp    (instr.aluForm.aluOp),
        .operandA (acc),
        .operandB (aluOperandB),
        .result   (aluResult)
    );

    // zero test sees the accumulator before this instruction
    assign jumpTarget = instr.addrForm.field[addrWidth-1:0];
    assign jumpTaken  = pop && ((opcode == opJump) ||
                                ((opcode == opJumpZero) && (acc == '0)));
    // buffer already holds the fall-through path, so such a jump needs no flush
    assign nextAddr   = headAddr + 1'b1;

    assign isHalt = pop && (opcode == opHalt);
    assign isOut  = pop && (opcode == opOut);

    always_ff @(posedge clock) begin
        if (rst) begin
            acc      <= '0;
            redirect <= 1'b0;
            haltReq  <= 1'b0;
            halted   <= 1'b0;
            outValid <= 1'b0;
        end else begin
            redirect <= jumpTaken && (jumpTarget != nextAddr);
            haltReq  <= isHalt;
            outValid <= isOut;
            if (isHalt) begin
                halted <= 1'b1;
            end
            if (pop) begin
                case (opcode)
                    opLdi:              acc <= ldiValue;
                    opLoad:             acc <= memWord;
                    opAluImm, opAluMem: acc <= aluResult;
                    // store, jumps, out, halt and unused codes keep acc
                    default:            acc <= acc;
                endcase
            end
        end
    end

    // payload side
    always_ff @(posedge clock) begin
        redirectAddr <= jumpTarget;
        // value before any update from this cycle
        if (isOut) begin
            outData <= acc;
        end
        if (pop && (opcode == opStore)) begin
            dataMem[memAddr] <= acc;
        end
    end

endmodule

// File: fetch/fetchUnit.sv
module fetchUnit (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         almostFull,
    input  logic                         redirect,
    input  logic [cpuPkg::addrWidth-1:0] redirectAddr,
    input  logic                         haltReq,
    input  logic [cpuPkg::dataWidth-1:0] readData,
    output logic                         readEnable,
    output logic [cpuPkg::addrWidth-1:0] readAddr,
    output logic                         push,
    output logic [cpuPkg::dataWidth-1:0] pushWord,
    output logic [cpuPkg::addrWidth-1:0] pushAddr,
    output logic                         running
);
    import cpuPkg::*;

    logic [addrWidth-1:0] pc;
    // one read in flight at most, returns the cycle after issue
    logic                 pending;
    logic [addrWidth-1:0] pendingAddr;

    // no new read while the buffer is nearly full
    // a redirect or halt cycle also issues nothing, next read follows it
    assign readEnable = running & ~almostFull & ~redirect & ~haltReq;
    assign readAddr   = pc;

    // word in flight is stale if a redirect lands as it returns
    assign push     = pending & ~redirect;
    assign pushWord = readData;
    assign pushAddr = pendingAddr;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
            pending <= 1'b0;
        end else begin
            // low during redirect, so the old read is dropped
            pending <= readEnable;
            if (haltReq) begin
                running <= 1'b0;
            end else if (start) begin
                running <= 1'b1;
                pc      <= '0;
            end else if (redirect) begin
                pc <= redirectAddr;
            end else if (readEnable) begin
                // wraps 255 to 0
                pc <= pc + 1'b1;
            end
        end
    end

    // address tag follows its word to the buffer
    always_ff @(posedge clock) begin
        if (readEnable) begin
            pendingAddr <= pc;
        end
    end

endmodule

// File: filelist.f
common/cpuPkg.sv
rtl/instrMemory.sv
fetch/fetchUnit.sv
rtl/instrBuffer.sv
execute/aluUnit.sv
execute/executeUnit.sv
rtl/cpuTop.sv
sim/clockGen.sv
sim/cpuTb.sv

// File: rtl/cpuTop.sv
module cpuTop (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         progWrite,
    input  logic [cpuPkg::addrWidth-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0] progData,
    input  logic                         start,
    output logic                         running,
    output logic                         halted,
    output logic                         outValid,
    output logic [cpuPkg::dataWidth-1:0] outData
);
    import cpuPkg::*;

    // memory to fetch
    logic                 readEnable;
    logic [addrWidth-1:0] readAddr;
    logic [dataWidth-1:0] readData;

    // fetch to buffer
    logic                 push;
    logic [dataWidth-1:0] pushWord;
    logic [addrWidth-1:0] pushAddr;
    logic                 almostFull;

    // buffer to execute
    logic                 pop;
    logic [dataWidth-1:0] headWord;
    logic [addrWidth-1:0] headAddr;
    logic                 empty;

    // execute back to fetch
    logic                 redirect;
    logic [addrWidth-1:0] redirectAddr;
    logic                 haltReq;

    instrMemory instrMemoryInst (
        .clock      (clock),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .readEnable (readEnable),
        .readAddr   (readAddr),
        .readData   (readData)
    );

    fetchUnit fetchInst (
        .clock        (clock),
        .rst          (rst),
        .start        (start),
        .almostFull   (almostFull),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .haltReq      (haltReq),
        .readData     (readData),
        .readEnable   (readEnable),
        .readAddr     (readAddr),
        .push         (push),
        .pushWord     (pushWord),
        .pushAddr     (pushAddr),
        .running      (running)
    );

    // a taken jump empties the buffer
    instrBuffer bufferInst (
        .clock      (clock),
        .rst        (rst),
        .push       (push),
        .pushWord   (pushWord),
        .pushAddr   (pushAddr),
        .pop        (pop),
        .flush      (redirect),
        .headWord   (headWord),
        .headAddr   (headAddr),
        .empty      (empty),
        .almostFull (almostFull)
    );

    executeUnit executeInst (
        .clock        (clock),
        .rst          (rst),
        .headWord     (headWord),
        .headAddr     (headAddr),
        .empty        (empty),
        .pop          (pop),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .haltReq      (haltReq),
        .halted       (halted),
        .outValid     (outValid),
        .outData      (outData)
    );

endmodule

// File: rtl/instrBuffer.sv
module instrBuffer (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         push,
    input  logic [cpuPkg::dataWidth-1:0] pushWord,
    input  logic [cpuPkg::addrWidth-1:0] pushAddr,
    input  logic                         pop,
    input  logic                         flush,
    output logic [cpuPkg::dataWidth-1:0] headWord,
    output logic [cpuPkg::addrWidth-1:0] headAddr,
    output logic                         empty,
    output logic                         almostFull
);
    import cpuPkg::*;

    // word and address pairs
    logic [dataWidth-1:0] wordMem [0:bufferDepth-1];
    logic [addrWidth-1:0] addrMem [0:bufferDepth-1];

    logic [bufferPtrWidth-1:0]   wrPtr;
    logic [bufferPtrWidth-1:0]   rdPtr;
    logic [bufferCountWidth-1:0] count;
    logic                        full;
    logic                        doPush;
    logic                        doPop;

    assign empty      = (count == '0);
    assign full       = (count == bufferCountWidth'(bufferDepth));
    // one free slot left, enough for the read in flight
    assign almostFull = (count >= bufferCountWidth'(bufferDepth - 1));

    assign doPush = push & ~full;
    assign doPop  = pop & ~empty;

    // head is visible without a pop
    assign headWord = wordMem[rdPtr];
    assign headAddr = addrMem[rdPtr];

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            // flush wins over a push in the same cycle
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push with pop leaves the count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clock) begin
        if (doPush && !flush) begin
            wordMem[wrPtr] <= pushWord;
            addrMem[wrPtr] <= pushAddr;
        end
    end

endmodule

// File: rtl/instrMemory.sv
module instrMemory (
    input  logic                         clock,
    input  logic                         progWrite,
    input  logic [cpuPkg::addrWidth-1:0] progAddr,
    input  logic [cpuPkg::dataWidth-1:0] progData,
    input  logic                         readEnable,
    input  logic [cpuPkg::addrWidth-1:0] readAddr,
    output logic [cpuPkg::dataWidth-1:0] readData
);
    import cpuPkg::*;

    // program storage, one word per address
    logic [dataWidth-1:0] memArray [0:(1 << addrWidth)-1];

    // load port, used while the machine is stopped
    always_ff @(posedge clock) begin
        if (progWrite) begin
            memArray[progAddr] <= progData;
        end
    end

    // fetch port, one cycle latency
    // same-address write in the same cycle returns the old word
    always_ff @(posedge clock) begin
        if (readEnable) begin
            readData <= memArray[readAddr];
        end
    end

endmodule

// File: sim/clockGen.sv
module clockGen (
    output logic clock
);

    // free-running clock, period of 4 time units
    initial begin
        clock = 1'b0;
    end

    always begin
        #2 clock = ~clock;
    end

endmodule

// File: sim/cpuTb.sv
module cpuTb;
    import cpuPkg::*;

    localparam int numTests   = 9;
    localparam int progLength = 16;
    localparam int maxOutputs = 4;
    localparam int waitLimit  = 200;

    logic                 clock;
    logic                 rst;
    logic                 progWrite;
    logic [addrWidth-1:0] progAddr;
    logic [dataWidth-1:0] progData;
    logic                 start;
    logic                 running;
    logic                 halted;
    logic                 outValid;
    logic [dataWidth-1:0] outData;

    // flat stimulus table with one slice per entry
    logic [dataWidth-1:0] progWords [0:numTests*progLength-1];
    logic [dataWidth-1:0] expWords  [0:numTests*maxOutputs-1];
    int                   outCounts [0:numTests-1];
    int                   currentTest;

    clockGen clockInst (
        .clock (clock)
    );

    cpuTop dut_i (
        .clock     (clock),
        .rst       (rst),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .start     (start),
        .running   (running),
        .halted    (halted),
        .outValid  (outValid),
        .outData   (outData)
    );

    task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                              input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("error %s in entry %0d: got 0x%h, expected 0x%h",
                     name, currentTest, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timed out in entry %0d while waiting for %s", currentTest, what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (8) @(negedge clock);
        rst = 1'b0;
    endtask

    // write the whole 16-word slot where unused words are halt
    task automatic loadProgram(input int entry);
        for (int i = 0; i < progLength; i++) begin
            @(negedge clock);
            progWrite = 1'b1;
            progAddr  = addrWidth'(i);
            progData  = progWords[entry * progLength + i];
        end
        @(negedge clock);
        progWrite = 1'b0;
    endtask

    task automatic pulseStart();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // stops on the sample that shows the strobe
    task automatic waitOutput(output logic [dataWidth-1:0] data);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!outValid && cycles < waitLimit);
        if (!outValid) begin
            reportTimeout("an outValid strobe");
        end else begin
            data = outData;
        end
    endtask

    // any strobe seen here is one too many
    task automatic waitHalted(output int strobes);
        int cycles;
        cycles  = 0;
        strobes = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (outValid) begin
                strobes++;
            end
        end while (!halted && cycles < waitLimit);
        if (!halted) begin
            reportTimeout("halted");
        end
    endtask

    initial begin : mainSeq
        logic [dataWidth-1:0] got;
        int                   extra;

        rst         = 1'b1;
        progWrite   = 1'b0;
        progAddr    = '0;
        progData    = '0;
        start       = 1'b0;
        currentTest = 0;

        progWords = '{
            // ldi 0xabc, out
            16'h1ABC, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // add, sub below zero, mul past 16 bits, div by zero
            16'h1123, 16'h4045, 16'h8000, 16'h1010, 16'h4120, 16'h8000, 16'h1FFF, 16'h4221,
            16'h8000, 16'h1064, 16'h4300, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // shl, shr, rol with bit 15 wrapping, ror with bit 0 wrapping
            16'h1801, 16'h4400, 16'h8000, 16'h1801, 16'h4500, 16'h8000, 16'h1000, 16'h4102,
            16'h4600, 16'h8000, 16'h1003, 16'h4700, 16'h8000, 16'h9000, 16'h9000, 16'h9000,
            // and, or, xor, nor
            16'h10F0, 16'h483C, 16'h8000, 16'h10F0, 16'h490F, 16'h8000, 16'h10F0, 16'h4AFF,
            16'h8000, 16'h10F0, 16'h4B0F, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // nand, xnor, greater false on equal values, equal true
            16'h10F0, 16'h4C3C, 16'h8000, 16'h10F0, 16'h4DFF, 16'h8000, 16'h10FF, 16'h4EFF,
            16'h8000, 16'h1042, 16'h4F42, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // greater true, equal false, div with a remainder, greater false on a smaller value
            16'h1100, 16'h4EFF, 16'h8000, 16'h1042, 16'h4F43, 16'h8000, 16'h1064, 16'h4307,
            16'h8000, 16'h1010, 16'h4E20, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // store to 0x10, load back, then add and sub from memory
            16'h1123, 16'h3010, 16'h1456, 16'h2010, 16'h8000, 16'h1200, 16'h5010, 16'h8000,
            16'h5110, 16'h8000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // jump over two fetched words that would print 0xbad
            16'h1011, 16'h6004, 16'h1BAD, 16'h8000, 16'h8000, 16'h9000, 16'h9000, 16'h9000,
            16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000,
            // countdown from 3 until jz leaves the loop
            16'h1003, 16'h8000, 16'h4101, 16'h7005, 16'h6001, 16'h9000, 16'h9000, 16'h9000,
            16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000, 16'h9000
        };

        // hand-computed from the isa with zero padding
        expWords = '{
            16'h0ABC, 16'h0000, 16'h0000, 16'h0000,
            16'h0168, 16'hFFF0, 16'h0FDF, 16'hFFFF,
            16'h1002, 16'h0400, 16'hFFFD, 16'h8001,
            16'h0030, 16'h00FF, 16'h000F, 16'hFF00,
            16'hFFCF, 16'hFFF0, 16'h0000, 16'h0001,
            16'h0001, 16'h0000, 16'h000E, 16'h0000,
            16'h0123, 16'h0323, 16'h0200, 16'h0000,
            16'h0011, 16'h0000, 16'h0000, 16'h0000,
            16'h0003, 16'h0002, 16'h0001, 16'h0000
        };
        outCounts = '{1, 4, 4, 4, 4, 4, 3, 1, 3};

        for (int t = 0; t < numTests; t++) begin
            currentTest = t;
            applyReset();
            checkValue("halted", halted, '0);
            loadProgram(t);
            pulseStart();
            // running rises the cycle after start
            checkValue("running", running, 16'h0001);
            for (int k = 0; k < outCounts[t]; k++) begin
                waitOutput(got);
                checkValue("outData", got, expWords[t * maxOutputs + k]);
            end
            waitHalted(extra);
            checkValue("outValid count", outCounts[t] + extra, outCounts[t]);
            // running drops one cycle after halted
            @(negedge clock);
            checkValue("running", running, '0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule
